// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := btac_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/btac.sv
`timescale 1ns/1ps

module btac (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          clear,
  input  logic [btac_cfg_pkg::xlen-1:0] get_pc,
  input  logic                          taken,
  input  logic [btac_cfg_pkg::xlen-1:0] taddr,
  input  logic [btac_cfg_pkg::xlen-1:0] tpc,
  input  btac_types_pkg::upd_op_t       upd_op,
  input  logic [btac_cfg_pkg::xlen-1:0] upd_pc,
  input  logic [btac_cfg_pkg::xlen-1:0] upd_addr,
  input  logic [btac_cfg_pkg::xlen-1:0] upd_npc,
  output logic                          pred_branch,
  output logic [btac_cfg_pkg::xlen-1:0] pred_baddr,
  output logic [btac_cfg_pkg::xlen-1:0] pred_pc,
  output logic                          pred_miss,
  output logic [btac_cfg_pkg::xlen-1:0] pred_maddr,
  output logic [btac_cfg_pkg::xlen-1:0] pred_raddr,
  output logic                          pred_rest
);
  import btac_cfg_pkg::*;
  import btac_types_pkg::*;

  generate
    if (btac_enable) begin : gen_cache
      logic                  wen;
      logic [index_bits-1:0] waddr;
      logic [entry_bits-1:0] wdata;
      logic [index_bits-1:0] raddr;
      logic [entry_bits-1:0] rdata;

      btb_array btb_array_0 (
        .clock (clock),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
      );

      btac_ctrl btac_ctrl_0 (
        .clock       (clock),
        .reset       (reset),
        .clear       (clear),
        .get_pc      (get_pc),
        .taken       (taken),
        .taddr       (taddr),
        .tpc         (tpc),
        .upd_op      (upd_op),
        .upd_pc      (upd_pc),
        .upd_addr    (upd_addr),
        .upd_npc     (upd_npc),
        .rdata       (rdata),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .raddr       (raddr),
        .pred_branch (pred_branch),
        .pred_baddr  (pred_baddr),
        .pred_pc     (pred_pc),
        .pred_miss   (pred_miss),
        .pred_maddr  (pred_maddr),
        .pred_raddr  (pred_raddr),
        .pred_rest   (pred_rest)
      );
    end else begin : gen_tie_off
      // no cache, so fetch never gets a prediction or a redirect.
      assign pred_branch = 1'b0;
      assign pred_baddr = '0;
      assign pred_pc = '0;
      assign pred_miss = 1'b0;
      assign pred_maddr = '0;
      assign pred_raddr = '0;
      assign pred_rest = 1'b0;
    end
  endgenerate

endmodule

// File: design/btac_cfg_pkg.sv
package btac_cfg_pkg;

  // every pc, target and fall-through address is this wide.
  localparam int xlen = 32;

  // direct-mapped table size and its index width.
  localparam int btb_entries = 16;
  localparam int index_bits = 4; // log2 of btb_entries.

  // one entry holds the source pc (tag), the target and the fall-through pc, high to low.
  localparam int entry_bits = 3 * xlen;

  // when 0 the top level builds no cache and ties every output to zero.
  localparam bit btac_enable = 1'b1;

endpackage

// File: design/btac_ctrl.sv
`timescale 1ns/1ps

module btac_ctrl (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                clear,
  input  logic [btac_cfg_pkg::xlen-1:0]       get_pc,
  input  logic                                taken,
  input  logic [btac_cfg_pkg::xlen-1:0]       taddr,
  input  logic [btac_cfg_pkg::xlen-1:0]       tpc,
  input  btac_types_pkg::upd_op_t             upd_op,
  input  logic [btac_cfg_pkg::xlen-1:0]       upd_pc,
  input  logic [btac_cfg_pkg::xlen-1:0]       upd_addr,
  input  logic [btac_cfg_pkg::xlen-1:0]       upd_npc,
  input  logic [btac_cfg_pkg::entry_bits-1:0] rdata,
  output logic                                wen,
  output logic [btac_cfg_pkg::index_bits-1:0] waddr,
  output logic [btac_cfg_pkg::entry_bits-1:0] wdata,
  output logic [btac_cfg_pkg::index_bits-1:0] raddr,
  output logic                                pred_branch,
  output logic [btac_cfg_pkg::xlen-1:0]       pred_baddr,
  output logic [btac_cfg_pkg::xlen-1:0]       pred_pc,
  output logic                                pred_miss,
  output logic [btac_cfg_pkg::xlen-1:0]       pred_maddr,
  output logic [btac_cfg_pkg::xlen-1:0]       pred_raddr,
  output logic                                pred_rest
);
  import btac_cfg_pkg::*;
  import btac_types_pkg::*;

  logic [xlen-1:0] lookup_pc;
  track_state_t    state;
  track_state_t    state_next;
  logic [xlen-1:0] taddr_q;
  logic [xlen-1:0] tpc_q;
  logic            resolved;
  logic            jumped;
  logic            pending;
  logic [xlen-1:0] taddr_eff;
  logic [xlen-1:0] tpc_eff;

  assign resolved = upd_op != op_none;
  assign jumped = upd_op inside {op_branch_t, op_jal, op_jalr};

  // a taken report in this cycle counts as pending and overrides the stored prediction.
  assign pending = (state == pred_pending) || taken;
  assign taddr_eff = taken ? taddr : taddr_q;
  assign tpc_eff = taken ? tpc : tpc_q;

  // lookup stage. The table is read with this index in the following cycle.
  always_ff @(posedge clock) begin
    if (!reset) begin
      raddr <= '0;
      lookup_pc <= '0;
    end else if (!clear) begin
      raddr <= get_pc[index_bits:1];
      lookup_pc <= get_pc;
    end
  end

  always_comb begin
    pred_branch = 1'b0;
    pred_baddr = '0;
    pred_pc = '0;
    if (!clear) begin
      pred_branch = (|rdata) && (rdata[entry_bits-1 -: xlen] == lookup_pc); // tag match.
      pred_baddr = rdata[2*xlen-1 -: xlen];
      pred_pc = rdata[xlen-1:0];
    end
  end

  // update stage. Only jumped outcomes are written, one cycle after they resolve.
  always_ff @(posedge clock) begin
    if (!reset) begin
      wen <= 1'b0;
    end else begin
      wen <= !clear && jumped;
    end
  end

  always_ff @(posedge clock) begin
    waddr <= upd_pc[index_bits:1];
    wdata <= {upd_pc, upd_addr, upd_npc};
  end

  // miss check against the prediction that fetch followed.
  always_comb begin
    pred_miss = 1'b0;
    pred_maddr = '0;
    state_next = taken ? pred_pending : state;
    if (!clear && resolved) begin
      if (!pending) begin
        if (jumped) begin
          pred_miss = 1'b1; // fetch fell through but the instruction jumped.
          pred_maddr = upd_addr;
        end
      end else begin
        state_next = pred_idle;
        if (upd_op == op_branch_nt) begin
          pred_miss = 1'b1;
          pred_maddr = tpc_eff;
        end else begin
          pred_miss = upd_addr != taddr_eff; // wrong target.
          pred_maddr = upd_addr;
        end
      end
    end
    if (clear) begin
      state_next = pred_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= pred_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (clear) begin
      taddr_q <= '0;
      tpc_q <= '0;
    end else if (taken) begin
      taddr_q <= taddr;
      tpc_q <= tpc;
    end
  end

  assign pred_raddr = clear ? '0 : upd_addr;
  assign pred_rest = !clear && (upd_op == op_jal || upd_op == op_jalr); // restart on jumps.

endmodule

// File: design/btac_types_pkg.sv
package btac_types_pkg;

  // kind of instruction reported by execute when it resolves.
  typedef enum logic [2:0] {
    op_none,
    op_branch_nt, // conditional branch, not taken.
    op_branch_t,  // conditional branch, taken.
    op_jal,
    op_jalr
  } upd_op_t;

  // whether fetch has followed a taken prediction that execute has not resolved yet.
  typedef enum logic {
    pred_idle,
    pred_pending
  } track_state_t;

endpackage

// File: design/btb_array.sv
`timescale 1ns/1ps

module btb_array (
  input  logic                                clock,
  input  logic                                wen,
  input  logic [btac_cfg_pkg::index_bits-1:0] waddr,
  input  logic [btac_cfg_pkg::entry_bits-1:0] wdata,
  input  logic [btac_cfg_pkg::index_bits-1:0] raddr,
  output logic [btac_cfg_pkg::entry_bits-1:0] rdata
);
  import btac_cfg_pkg::*;

  // an all-zero entry never hits, so the table starts empty.
  logic [entry_bits-1:0] mem [btb_entries] = '{default: '0};

  assign rdata = mem[raddr]; // read is combinational on the registered index.

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

// File: test/btac_clock_gen.sv
`timescale 1ns/1ps

module btac_clock_gen (
  output logic clock,
  output logic reset
);
  localparam int period_ns = 40;
  localparam int reset_cycles = 5;

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0; // reset is active low and held for the first few edges.
    repeat (reset_cycles) @(posedge clock);
    #2 reset = 1'b1;
  end

endmodule

// File: test/btac_golden.txt
# one record per clock cycle, every field in hex. upd_op: 0 none 1 branch_nt 2 branch_t 3 jal 4 jalr
# test clear get_pc rnd taken taddr tpc upd_op upd_pc upd_addr upd_npc
#   mask (1 lookup, 2 miss, 4 redirect) branch baddr pc miss maddr raddr rest
1 0 100 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
1 0 2468 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
1 0 abc 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
1 0 0 1 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
2 0 0 0 0 0 0 3 1008 2000 100c 6 0 0 0 1 2000 2000 1
2 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
2 0 1008 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
2 0 1028 0 0 0 0 0 0 0 0 7 1 2000 100c 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 7 0 2000 100c 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
3 0 0 0 0 0 0 2 1110 1200 1114 7 0 0 0 1 1200 1200 0
3 0 0 0 0 0 0 1 1120 1300 1124 7 0 0 0 0 0 1300 0
3 0 0 0 0 0 0 0 0 abcd 0 7 0 0 0 0 0 abcd 0
3 0 0 0 0 0 0 4 1134 1400 1138 7 0 0 0 1 1400 1400 1
3 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
4 0 0 0 1 1500 1444 0 0 0 0 7 0 0 0 0 0 0 0
4 0 0 0 0 0 0 1 1440 1500 1444 7 0 0 0 1 1444 1500 0
4 0 0 0 1 1600 1554 0 0 0 0 7 0 0 0 0 0 0 0
4 0 0 0 0 0 0 2 1550 1600 1554 7 0 0 0 0 1600 1600 0
4 0 0 0 0 0 0 2 1550 1600 1554 7 0 0 0 1 1600 1600 0
4 0 0 0 1 1700 1666 3 1662 1780 1666 7 0 0 0 1 1780 1780 1
4 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
4 0 0 0 0 0 0 1 1700 1800 1704 7 0 0 0 0 0 1800 0
5 0 0 0 0 0 0 4 1802 1900 1806 7 0 0 0 1 1900 1900 1
5 0 0 0 0 0 0 2 1812 1a00 1816 7 0 0 0 1 1a00 1a00 0
5 0 0 0 1 1b00 1b26 0 0 0 0 7 0 0 0 0 0 0 0
5 1 1008 0 0 0 0 3 1b22 1c00 1b26 7 0 0 0 0 0 0 0
5 0 0 0 0 0 0 2 1b22 1b00 1b26 7 0 0 0 1 1b00 1b00 0
5 0 1008 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
5 1 0 0 0 0 0 4 1c02 1d00 1c06 7 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 7 1 2000 100c 0 0 0 0
5 0 0 1 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0

// File: test/btac_properties.sv
`timescale 1ns/1ps

module btac_properties (
  input logic                          clock,
  input logic                          reset,
  input logic                          clear,
  input btac_types_pkg::upd_op_t       upd_op,
  input logic                          pred_branch,
  input logic [btac_cfg_pkg::xlen-1:0] pred_baddr,
  input logic [btac_cfg_pkg::xlen-1:0] pred_pc,
  input logic                          pred_miss,
  input logic [btac_cfg_pkg::xlen-1:0] pred_maddr,
  input logic [btac_cfg_pkg::xlen-1:0] pred_raddr,
  input logic                          pred_rest
);
  import btac_types_pkg::*;

  logic outputs_zero;
  logic restart_op;
  int   failures = 0; // number of assertion failures so far.

  assign outputs_zero = !pred_branch && (pred_baddr == '0) && (pred_pc == '0) && !pred_miss &&
                        (pred_maddr == '0) && (pred_raddr == '0) && !pred_rest;
  assign restart_op = upd_op inside {op_jal, op_jalr}; // only jumps restart fetch.

  clear_zeroes_outputs: assert property (@(posedge clock) disable iff (!reset)
    clear |-> outputs_zero)
    else begin
      $error("an output is nonzero while clear is high");
      failures++;
    end

  restart_on_jumps: assert property (@(posedge clock) disable iff (!reset)
    !clear |-> (pred_rest == restart_op))
    else begin
      $error("pred_rest does not follow the jal and jalr opcodes");
      failures++;
    end

  miss_needs_resolution: assert property (@(posedge clock) disable iff (!reset)
    pred_miss |-> (upd_op != op_none))
    else begin
      $error("pred_miss is high without a resolved instruction");
      failures++;
    end

endmodule

// File: test/btac_tb.sv
`timescale 1ns/1ps

module btac_tb;
  import btac_cfg_pkg::*;
  import btac_types_pkg::*;

  localparam int clock_period_ns = 40;
  localparam int drive_delay_ns = 2;
  localparam int field_count = 19;

  // one golden record holds the inputs of one cycle and the outputs expected in it.
  typedef struct packed {
    logic [7:0]      test;
    logic            clear;
    logic [xlen-1:0] get_pc;
    logic            rnd;
    logic            taken;
    logic [xlen-1:0] taddr;
    logic [xlen-1:0] tpc;
    logic [2:0]      op;
    logic [xlen-1:0] upd_pc;
    logic [xlen-1:0] upd_addr;
    logic [xlen-1:0] upd_npc;
    logic [2:0]      mask;
    logic            branch;
    logic [xlen-1:0] baddr;
    logic [xlen-1:0] ppc;
    logic            miss;
    logic [xlen-1:0] maddr;
    logic [xlen-1:0] raddr;
    logic            rest;
  } vector_t;

  logic            clock;
  logic            reset;
  logic            clear;
  logic [xlen-1:0] get_pc;
  logic            taken;
  logic [xlen-1:0] taddr;
  logic [xlen-1:0] tpc;
  upd_op_t         upd_op;
  logic [xlen-1:0] upd_pc;
  logic [xlen-1:0] upd_addr;
  logic [xlen-1:0] upd_npc;
  logic            pred_branch;
  logic [xlen-1:0] pred_baddr;
  logic [xlen-1:0] pred_pc;
  logic            pred_miss;
  logic [xlen-1:0] pred_maddr;
  logic [xlen-1:0] pred_raddr;
  logic            pred_rest;

  vector_t vectors[$];
  int      num_records = 0;
  bit      loaded = 1'b0;
  bit      load_error = 1'b0;
  int      record_index = 0;
  int      current_test = -1;
  int      test_errors = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;

  btac_clock_gen clock_gen_0 (.clock(clock), .reset(reset));

  btac uut (
    .clock(clock), .reset(reset), .clear(clear), .get_pc(get_pc),
    .taken(taken), .taddr(taddr), .tpc(tpc),
    .upd_op(upd_op), .upd_pc(upd_pc), .upd_addr(upd_addr), .upd_npc(upd_npc),
    .pred_branch(pred_branch), .pred_baddr(pred_baddr), .pred_pc(pred_pc),
    .pred_miss(pred_miss), .pred_maddr(pred_maddr),
    .pred_raddr(pred_raddr), .pred_rest(pred_rest)
  );

  bind btac btac_properties props (.*);

  task automatic read_golden();
    int              fd;
    int              count;
    string           line;
    logic [31:0]     f [field_count];
    vector_t         v;
    fd = $fopen("test/btac_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file test/btac_golden.txt");
      load_error = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      count = $fgets(line, fd);
      if (line.len() == 0 || line[0] == "#") continue; // comment lines start with a hash.
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
      if (count == field_count) begin
        v.test = f[0][7:0];
        v.clear = f[1][0];
        v.get_pc = f[2];
        v.rnd = f[3][0];
        v.taken = f[4][0];
        v.taddr = f[5];
        v.tpc = f[6];
        v.op = f[7][2:0];
        v.upd_pc = f[8];
        v.upd_addr = f[9];
        v.upd_npc = f[10];
        v.mask = f[11][2:0];
        v.branch = f[12][0];
        v.baddr = f[13];
        v.ppc = f[14];
        v.miss = f[15][0];
        v.maddr = f[16];
        v.raddr = f[17];
        v.rest = f[18][0];
        vectors.push_back(v);
      end else if (count > 0) begin
        $display("the golden file has a malformed line: %s", line);
        load_error = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_inputs(input vector_t v);
    clear = v.clear;
    get_pc = v.rnd ? $urandom() : v.get_pc; // a filler pc is only seen in a masked cycle.
    taken = v.taken;
    taddr = v.taddr;
    tpc = v.tpc;
    upd_op = upd_op_t'(v.op);
    upd_pc = v.upd_pc;
    upd_addr = v.upd_addr;
    upd_npc = v.upd_npc;
  endtask

  task automatic check_field(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
    else begin
      $display("ERR %s expected 0x%08h actual 0x%08h in record %0d",
               name, expected, actual, record_index);
      test_errors++;
    end
  endtask

  task automatic check_outputs(input vector_t v);
    if (v.mask[0]) begin
      check_field("pred_branch", 32'(pred_branch), 32'(v.branch));
      check_field("pred_baddr", pred_baddr, v.baddr);
      check_field("pred_pc", pred_pc, v.ppc);
    end
    if (v.mask[1]) begin
      check_field("pred_miss", 32'(pred_miss), 32'(v.miss));
      check_field("pred_maddr", pred_maddr, v.maddr);
    end
    if (v.mask[2]) begin
      check_field("pred_raddr", pred_raddr, v.raddr);
      check_field("pred_rest", 32'(pred_rest), 32'(v.rest));
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %0d passed", current_test);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", current_test, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    clear = 1'b0;
    get_pc = '0;
    taken = 1'b0;
    taddr = '0;
    tpc = '0;
    upd_op = op_none;
    upd_pc = '0;
    upd_addr = '0;
    upd_npc = '0;
    void'($urandom(8));
    read_golden();
    num_records = vectors.size();
    if (num_records == 0 && !load_error) begin
      $display("the golden file holds no records");
      load_error = 1'b1;
    end
    loaded = 1'b1;
    wait (reset === 1'b1);
    foreach (vectors[i]) begin
      if (int'(vectors[i].test) != current_test) begin
        if (current_test >= 0) report_test();
        current_test = int'(vectors[i].test);
      end
      record_index = i;
      @(posedge clock);
      #(drive_delay_ns);
      apply_inputs(vectors[i]);
      #(clock_period_ns - drive_delay_ns - 1); // sample just before the next edge.
      check_outputs(vectors[i]);
    end
    if (current_test >= 0) report_test();
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && !load_error && uut.props.failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // the run may take one cycle per record plus reset and some margin.
  initial begin
    wait (loaded);
    #((num_records + 20) * clock_period_ns);
    $display("timeout: the run did not finish within %0d cycles", num_records + 20);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
design/btac_cfg_pkg.sv
design/btac_types_pkg.sv
design/btb_array.sv
design/btac_ctrl.sv
design/btac.sv
test/btac_clock_gen.sv
test/btac_properties.sv
test/btac_tb.sv
